//--- project.f
design/acpo_pkg.sv
design/act_relu.sv
design/max_pool.sv
design/pool_write_ctrl.sv
design/sram_bank.sv
design/acpo_top.sv
verification/tb_clk_gen.sv
verification/tb_acpo_top.sv

//--- run.sh
#!/bin/sh
# build and run the acpo testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_acpo_top \
    -f project.f \
    -o sim_acpo

out=$(./obj_dir/sim_acpo) || true
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

//--- verification/tb_acpo_top.sv
/* activation and pooling testbench */
`timescale 1ns/1ps

module tb_acpo_top;

    localparam int DRIVE_SKEW      = 10;                    // ns after the rising edge
    localparam int RESET_CYCLES    = 5;
    localparam int WRITE_DELAY     = 3;                     // write latency plus one
    localparam int WATCHDOG_CYCLES = 3000;                  // tests need a few hundred
    localparam int FLUSH_LANE      = 1;
    localparam int BYTE_MAX        = 255;

    logic                        clk;
    logic                        rst_n;
    acpo_pkg::acc_beat_t         acc [acpo_pkg::LANES];
    acpo_pkg::fc_beat_t          acc_fc;
    logic                        rd_sa_en;
    logic [acpo_pkg::RD_AW-1:0]  rd_sa_addr;
    logic                        rd_fc_en;
    logic [acpo_pkg::BUF_AW-1:0] rd_fc_addr;
    logic                        rd_tag_en;
    logic [acpo_pkg::RD_AW-1:0]  rd_tag_addr;
    acpo_pkg::data_t             rd_sa_data;
    acpo_pkg::data_t             rd_fc_data;
    acpo_pkg::tag_t              rd_tag_data;
    logic                        act_last;
    logic [acpo_pkg::LANES-1:0]  pool_last;

    // reference model
    acpo_pkg::data_t exp_sa  [acpo_pkg::LANES][acpo_pkg::BUF_DEPTH];
    acpo_pkg::tag_t  exp_tag [acpo_pkg::LANES][acpo_pkg::BUF_DEPTH];
    acpo_pkg::data_t exp_fc  [acpo_pkg::BUF_DEPTH];
    int              sa_wp   [acpo_pkg::LANES];
    int              fc_wp;
    int              win_cnt [acpo_pkg::LANES];
    acpo_pkg::data_t win_max [acpo_pkg::LANES];
    acpo_pkg::tag_t  win_tag [acpo_pkg::LANES];

    logic [15:0]     lfsr_state;
    int              mismatch_cnt;
    int              fail_cnt;

    tb_clk_gen #(.PERIOD_NS(100)) u_clk_gen (.clk_o(clk));

    acpo_top u_acpo_top (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .acc_i         (acc),
        .acc_fc_i      (acc_fc),
        .rd_sa_en_i    (rd_sa_en),
        .rd_sa_addr_i  (rd_sa_addr),
        .rd_fc_en_i    (rd_fc_en),
        .rd_fc_addr_i  (rd_fc_addr),
        .rd_tag_en_i   (rd_tag_en),
        .rd_tag_addr_i (rd_tag_addr),
        .rd_sa_data_o  (rd_sa_data),
        .rd_fc_data_o  (rd_fc_data),
        .rd_tag_data_o (rd_tag_data),
        .act_last_o    (act_last),
        .pool_last_o   (pool_last)
    );

    // galois form with taps x^16 + x^14 + x^13 + x^11
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | int'(lfsr_bit());
        end
        return r;
    endfunction

    // mode 0 negative, 1 above a byte, else in range
    function automatic logic signed [acpo_pkg::ACC_W-1:0] rand_acc(input int mode);
        int v;
        case (mode)
            0:       v = -1 - rand_bits(12);
            1:       v = 256 + rand_bits(13);
            default: v = rand_bits(8);
        endcase
        return v[acpo_pkg::ACC_W-1:0];
    endfunction

    function automatic logic signed [acpo_pkg::ACC_W-1:0] rand_acc_any();
        return rand_acc(rand_bits(2));
    endfunction

    function automatic acpo_pkg::data_t relu_ref(input logic signed [acpo_pkg::ACC_W-1:0] res);
        int v;
        v = int'(res);
        if (v < 0) begin
            return '0;
        end
        if (v > BYTE_MAX) begin
            return '1;
        end
        return v[acpo_pkg::DATA_W-1:0];
    endfunction

    function automatic acpo_pkg::tag_t to_tag(input int v);
        return v[acpo_pkg::TAG_W-1:0];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_SKEW);
    endtask

    task automatic idle_lane(input int lane);
        acc[lane].valid = 1'b0;
        acc[lane].last  = 1'b0;
    endtask

    task automatic idle_inputs();
        for (int l = 0; l < acpo_pkg::LANES; l++) begin
            idle_lane(l);
        end
        acc_fc.valid = 1'b0;
        acc_fc.last  = 1'b0;
    endtask

    task automatic drain();
        idle_inputs();
        repeat (WRITE_DELAY) next_cycle();
    endtask

    // windows of four that last can close early
    task automatic model_conv(input int lane, input logic signed [acpo_pkg::ACC_W-1:0] res,
                              input acpo_pkg::tag_t tag, input logic last);
        acpo_pkg::data_t v;
        v = relu_ref(res);
        if (win_cnt[lane] == 0) begin
            win_max[lane] = v;
            win_tag[lane] = tag;
        end else if (v > win_max[lane]) begin
            win_max[lane] = v;
        end
        win_cnt[lane]++;
        if (win_cnt[lane] == acpo_pkg::POOL_SIZE || last) begin
            exp_sa[lane][sa_wp[lane]]  = win_max[lane];
            exp_tag[lane][sa_wp[lane]] = win_tag[lane];
            sa_wp[lane]   = (sa_wp[lane] + 1) % acpo_pkg::BUF_DEPTH;
            win_cnt[lane] = 0;
        end
    endtask

    task automatic set_conv(input int lane, input logic signed [acpo_pkg::ACC_W-1:0] res,
                            input acpo_pkg::tag_t tag, input logic last);
        acc[lane].valid  = 1'b1;
        acc[lane].last   = last;
        acc[lane].result = res;
        acc[lane].tag    = tag;
        model_conv(lane, res, tag, last);
    endtask

    task automatic set_fc(input logic signed [acpo_pkg::ACC_W-1:0] res, input logic last);
        acc_fc.valid  = 1'b1;
        acc_fc.last   = last;
        acc_fc.result = res;
        exp_fc[fc_wp] = relu_ref(res);
        fc_wp = (fc_wp + 1) % acpo_pkg::BUF_DEPTH;
    endtask

    task automatic check_byte(input string sig, input acpo_pkg::data_t exp_v,
                              input acpo_pkg::data_t act_v);
        assert (act_v === exp_v) else begin
            mismatch_cnt++;
            $display("MISMATCH %s: expected %h, actual %h", sig, exp_v, act_v);
        end
    endtask

    task automatic check_tag(input string sig, input acpo_pkg::tag_t exp_v,
                             input acpo_pkg::tag_t act_v);
        assert (act_v === exp_v) else begin
            mismatch_cnt++;
            $display("MISMATCH %s: expected %h, actual %h", sig, exp_v, act_v);
        end
    endtask

    // bit LANES is act_last, the rest pool_last
    task automatic check_strobe(input string test, input int cyc,
                                input logic [acpo_pkg::LANES:0] exp_v);
        logic [acpo_pkg::LANES:0] seen;
        seen = {act_last, pool_last};
        assert (seen === exp_v) else begin
            fail_cnt++;
            $display("%s: last pulse missing or misplaced at cycle %0d, wanted %b but saw %b",
                     test, cyc, exp_v, seen);
        end
    endtask

    task automatic read_bank(input int lane, input int idx, output acpo_pkg::data_t b,
                             output acpo_pkg::tag_t t);
        int a;
        a = (lane << acpo_pkg::BUF_AW) | idx;
        rd_sa_en    = 1'b1;
        rd_tag_en   = 1'b1;
        rd_sa_addr  = a[acpo_pkg::RD_AW-1:0];
        rd_tag_addr = a[acpo_pkg::RD_AW-1:0];
        next_cycle();
        rd_sa_en  = 1'b0;
        rd_tag_en = 1'b0;
        b = rd_sa_data;
        t = rd_tag_data;
    endtask

    task automatic read_fc(input int idx, output acpo_pkg::data_t b);
        rd_fc_en   = 1'b1;
        rd_fc_addr = idx[acpo_pkg::BUF_AW-1:0];
        next_cycle();
        rd_fc_en = 1'b0;
        b = rd_fc_data;
    endtask

    task automatic check_bank(input int lane, input int start, input int n, input string test);
        acpo_pkg::data_t b;
        acpo_pkg::tag_t  t;
        int              idx;
        for (int k = 0; k < n; k++) begin
            idx = (start + k) % acpo_pkg::BUF_DEPTH;
            read_bank(lane, idx, b, t);
            check_byte($sformatf("%s rd_sa_data_o bank %0d entry %0d", test, lane, idx),
                       exp_sa[lane][idx], b);
            check_tag($sformatf("%s rd_tag_data_o bank %0d entry %0d", test, lane, idx),
                      exp_tag[lane][idx], t);
        end
    endtask

    task automatic test_reset();
        for (int c = 0; c < RESET_CYCLES; c++) begin
            next_cycle();
            check_strobe("reset", c, '0);
        end
        rst_n = 1'b1;
        for (int c = 0; c < 4; c++) begin
            next_cycle();
            check_strobe("after reset", c, '0);
        end
    endtask

    task automatic test_fc_activation();
        logic [acpo_pkg::LANES:0] exp_strobe;
        acpo_pkg::data_t          b;
        for (int c = 0; c < 22; c++) begin
            if (c < 20) begin
                set_fc(rand_acc(c % 4), c == 19);
            end else begin
                idle_inputs();
            end
            next_cycle();
            exp_strobe = '0;
            exp_strobe[acpo_pkg::LANES] = (c == 19);        // one cycle after the beat
            check_strobe("fc activation", c, exp_strobe);
        end
        drain();
        for (int i = 0; i < 20; i++) begin
            read_fc(i, b);
            check_byte($sformatf("rd_fc_data_o entry %0d", i), exp_fc[i], b);
        end
    endtask

    task automatic test_pool_tags();
        int start [acpo_pkg::LANES];
        for (int l = 0; l < acpo_pkg::LANES; l++) begin
            start[l] = sa_wp[l];
        end
        for (int k = 0; k < 16; k++) begin
            for (int l = 0; l < acpo_pkg::LANES; l++) begin
                set_conv(l, rand_acc_any(), to_tag((l << 7) + k), 1'b0);
            end
            next_cycle();
        end
        drain();
        for (int l = 0; l < acpo_pkg::LANES; l++) begin
            check_bank(l, start[l], 4, "pooling");
        end
    endtask

    task automatic test_partial_flush();
        logic [acpo_pkg::LANES:0] exp_strobe;
        int                       start;
        start = sa_wp[FLUSH_LANE];
        for (int c = 0; c < 9; c++) begin
            if (c < 6) begin
                set_conv(FLUSH_LANE, rand_acc_any(), to_tag(512 + c), c == 5);
            end else begin
                idle_inputs();
            end
            next_cycle();
            exp_strobe = '0;
            exp_strobe[FLUSH_LANE] = (c == 6);               // two cycles after the flagged beat
            check_strobe("partial flush", c, exp_strobe);
        end
        drain();
        check_bank(FLUSH_LANE, start, 2, "partial flush");
    endtask

    task automatic test_lane_independence();
        int                       start [acpo_pkg::LANES];
        logic [acpo_pkg::LANES:0] exp_strobe;
        for (int l = 0; l < acpo_pkg::LANES; l++) begin
            start[l] = sa_wp[l];
        end
        for (int c = 0; c < 28; c++) begin
            for (int l = 0; l < acpo_pkg::LANES; l++) begin
                if (c > 24) begin
                    idle_lane(l);
                end else if (c == 24) begin
                    set_conv(l, rand_acc_any(), to_tag((l << 8) | c), 1'b1);
                end else if (c % (l + 2) != 0) begin
                    set_conv(l, rand_acc_any(), to_tag((l << 8) | c), 1'b0);
                end else begin
                    idle_lane(l);
                end
            end
            next_cycle();
            exp_strobe = '0;
            if (c == 25) begin
                exp_strobe[acpo_pkg::LANES-1:0] = '1;       // every lane flushes together
            end
            check_strobe("independent lanes", c, exp_strobe);
        end
        drain();
        for (int l = 0; l < acpo_pkg::LANES; l++) begin
            check_bank(l, start[l],
                       (sa_wp[l] - start[l] + acpo_pkg::BUF_DEPTH) % acpo_pkg::BUF_DEPTH,
                       "independent lanes");
        end
    endtask

    task automatic test_fc_wrap();
        acpo_pkg::data_t b;
        for (int k = 0; k < 70; k++) begin
            set_fc(rand_acc_any(), 1'b0);
            next_cycle();
        end
        drain();
        for (int i = 0; i < acpo_pkg::BUF_DEPTH; i++) begin
            read_fc(i, b);
            check_byte($sformatf("wrap rd_fc_data_o entry %0d", i), exp_fc[i], b);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("error counts: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        rd_sa_en     = 1'b0;
        rd_fc_en     = 1'b0;
        rd_tag_en    = 1'b0;
        rd_sa_addr   = '0;
        rd_fc_addr   = '0;
        rd_tag_addr  = '0;
        acc_fc       = '0;
        lfsr_state   = 16'd64;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        fc_wp        = 0;
        for (int l = 0; l < acpo_pkg::LANES; l++) begin
            acc[l]     = '0;
            sa_wp[l]   = 0;
            win_cnt[l] = 0;
        end
        test_reset();
        test_fc_activation();
        test_pool_tags();
        test_partial_flush();
        test_lane_independence();
        test_fc_wrap();
        $display("error counts: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt + fail_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verification/tb_clk_gen.sv
/* testbench clock source */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2) clk_o = ~clk_o;                    // 50% duty
    end

endmodule

//--- design/acpo_top.sv
/* CNN activation and pooling stage */
`timescale 1ns/1ps

module acpo_top (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  acpo_pkg::acc_beat_t         acc_i         [acpo_pkg::LANES],
    input  acpo_pkg::fc_beat_t          acc_fc_i,
    input  logic                        rd_sa_en_i,
    input  logic [acpo_pkg::RD_AW-1:0]  rd_sa_addr_i,
    input  logic                        rd_fc_en_i,
    input  logic [acpo_pkg::BUF_AW-1:0] rd_fc_addr_i,
    input  logic                        rd_tag_en_i,
    input  logic [acpo_pkg::RD_AW-1:0]  rd_tag_addr_i,
    output acpo_pkg::data_t             rd_sa_data_o,
    output acpo_pkg::data_t             rd_fc_data_o,
    output acpo_pkg::tag_t              rd_tag_data_o,
    output logic                        act_last_o,
    output logic [acpo_pkg::LANES-1:0]  pool_last_o
);

    acpo_pkg::act_beat_t         act       [acpo_pkg::LANES];
    acpo_pkg::act_fc_t           act_fc;
    acpo_pkg::act_beat_t         pool      [acpo_pkg::LANES];

    logic [acpo_pkg::LANES-1:0]  sa_we;
    logic [acpo_pkg::BUF_AW-1:0] sa_waddr  [acpo_pkg::LANES];
    logic                        fc_we;
    logic [acpo_pkg::BUF_AW-1:0] fc_waddr  [1];

    acpo_pkg::data_t             sa_wdata  [acpo_pkg::LANES];
    acpo_pkg::tag_t              tag_wdata [acpo_pkg::LANES];
    acpo_pkg::data_t             fc_wdata  [1];

    act_relu u_act (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .acc_i    (acc_i),
        .acc_fc_i (acc_fc_i),
        .act_o    (act),
        .act_fc_o (act_fc)
    );

    max_pool u_pool (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .act_i   (act),
        .pool_o  (pool)
    );

    pool_write_ctrl u_ctrl (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .pool_i      (pool),
        .act_fc_i    (act_fc),
        .sa_we_o     (sa_we),
        .sa_waddr_o  (sa_waddr),
        .fc_we_o     (fc_we),
        .fc_waddr_o  (fc_waddr[0]),
        .pool_last_o (pool_last_o),
        .act_last_o  (act_last_o)
    );

    // split pooled beats into byte and tag lanes
    for (genvar l = 0; l < acpo_pkg::LANES; l++) begin : g_wdata
        assign sa_wdata[l]  = pool[l].value;
        assign tag_wdata[l] = pool[l].tag;
    end
    assign fc_wdata[0] = act_fc.value;

    sram_bank #(.entry_t(acpo_pkg::data_t), .BANKS(acpo_pkg::LANES)) u_sa_buf (
        .clk     (clk),
        .we_i    (sa_we),
        .waddr_i (sa_waddr),
        .wdata_i (sa_wdata),
        .rd_en_i (rd_sa_en_i),
        .raddr_i (rd_sa_addr_i),
        .rdata_o (rd_sa_data_o)
    );

    sram_bank #(.entry_t(acpo_pkg::data_t), .BANKS(1)) u_fc_buf (
        .clk     (clk),
        .we_i    (fc_we),
        .waddr_i (fc_waddr),
        .wdata_i (fc_wdata),
        .rd_en_i (rd_fc_en_i),
        .raddr_i (rd_fc_addr_i),
        .rdata_o (rd_fc_data_o)
    );

    sram_bank #(.entry_t(acpo_pkg::tag_t), .BANKS(acpo_pkg::LANES)) u_tag_buf (
        .clk     (clk),
        .we_i    (sa_we),                                     // paired with sa entries
        .waddr_i (sa_waddr),
        .wdata_i (tag_wdata),
        .rd_en_i (rd_tag_en_i),
        .raddr_i (rd_tag_addr_i),
        .rdata_o (rd_tag_data_o)
    );

endmodule

//--- design/sram_bank.sv
/* banked buffer, one read port */
`timescale 1ns/1ps

module sram_bank #(
    parameter type entry_t = acpo_pkg::data_t,
    parameter int  BANKS   = 1
) (
    input  logic                                       clk,
    input  logic [BANKS-1:0]                           we_i,
    input  logic [acpo_pkg::BUF_AW-1:0]                waddr_i [BANKS],
    input  entry_t                                     wdata_i [BANKS],
    input  logic                                       rd_en_i,
    input  logic [acpo_pkg::BUF_AW+$clog2(BANKS)-1:0]  raddr_i,
    output entry_t                                     rdata_o
);

    entry_t                      mem [BANKS][acpo_pkg::BUF_DEPTH];
    logic [acpo_pkg::BUF_AW-1:0] rd_row;
    entry_t                      rd_entry;

    assign rd_row = raddr_i[acpo_pkg::BUF_AW-1:0];

    if (BANKS == 1) begin : g_single
        assign rd_entry = mem[0][rd_row];
    end else begin : g_multi
        assign rd_entry = mem[raddr_i[acpo_pkg::BUF_AW +: $clog2(BANKS)]][rd_row];
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < BANKS; b++) begin
            if (we_i[b]) begin
                mem[b][waddr_i[b]] <= wdata_i[b];
            end
        end
        if (rd_en_i) begin
            rdata_o <= rd_entry;                              // old data on collision
        end
    end

endmodule

//--- design/pool_write_ctrl.sv
/* buffer write control */
`timescale 1ns/1ps

module pool_write_ctrl (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  acpo_pkg::act_beat_t        pool_i      [acpo_pkg::LANES],
    input  acpo_pkg::act_fc_t          act_fc_i,
    output logic [acpo_pkg::LANES-1:0] sa_we_o,
    output logic [acpo_pkg::BUF_AW-1:0] sa_waddr_o [acpo_pkg::LANES],
    output logic                       fc_we_o,
    output logic [acpo_pkg::BUF_AW-1:0] fc_waddr_o,
    output logic [acpo_pkg::LANES-1:0] pool_last_o,
    output logic                       act_last_o
);

    logic [acpo_pkg::BUF_AW-1:0] sa_cnt [acpo_pkg::LANES];   // next entry per bank
    logic [acpo_pkg::BUF_AW-1:0] fc_cnt;

    always_comb begin
        for (int l = 0; l < acpo_pkg::LANES; l++) begin
            sa_we_o[l]     = pool_i[l].valid;                 // tag buffer shares these
            sa_waddr_o[l]  = sa_cnt[l];
            pool_last_o[l] = pool_i[l].valid & pool_i[l].last;
        end
    end

    assign fc_we_o    = act_fc_i.valid;
    assign fc_waddr_o = fc_cnt;
    assign act_last_o = act_fc_i.valid & act_fc_i.last;

    // counters step on the write edge, wrapping at 64
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int l = 0; l < acpo_pkg::LANES; l++) begin
                sa_cnt[l] <= '0;
            end
            fc_cnt <= '0;
        end else begin
            for (int l = 0; l < acpo_pkg::LANES; l++) begin
                if (pool_i[l].valid) begin
                    sa_cnt[l] <= sa_cnt[l] + 1'b1;
                end
            end
            if (act_fc_i.valid) begin
                fc_cnt <= fc_cnt + 1'b1;
            end
        end
    end

endmodule

//--- design/max_pool.sv
/* per-lane 1-D max pooling */
`timescale 1ns/1ps

module max_pool (
    input  logic                clk,
    input  logic                rst_n_i,
    input  acpo_pkg::act_beat_t act_i  [acpo_pkg::LANES],
    output acpo_pkg::act_beat_t pool_o [acpo_pkg::LANES]
);

    logic [acpo_pkg::POOL_CW-1:0] cnt       [acpo_pkg::LANES];  // samples in window
    acpo_pkg::data_t              run_max   [acpo_pkg::LANES];
    acpo_pkg::tag_t               first_tag [acpo_pkg::LANES];

    acpo_pkg::data_t              cur_max   [acpo_pkg::LANES];
    acpo_pkg::tag_t               cur_tag   [acpo_pkg::LANES];
    logic                         close_win [acpo_pkg::LANES];

    acpo_pkg::act_beat_t          pool_q    [acpo_pkg::LANES];

    // window state including the incoming sample
    always_comb begin
        for (int l = 0; l < acpo_pkg::LANES; l++) begin
            if (cnt[l] == '0) begin
                cur_max[l] = act_i[l].value;                  // first sample opens window
                cur_tag[l] = act_i[l].tag;
            end else begin
                cur_max[l] = (act_i[l].value > run_max[l]) ? act_i[l].value : run_max[l];
                cur_tag[l] = first_tag[l];
            end
            close_win[l] = act_i[l].valid &
                           (act_i[l].last |
                            (cnt[l] == acpo_pkg::POOL_CW'(acpo_pkg::POOL_SIZE - 1)));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int l = 0; l < acpo_pkg::LANES; l++) begin
                cnt[l]          <= '0;
                pool_q[l].valid <= 1'b0;
                pool_q[l].last  <= 1'b0;
            end
        end else begin
            for (int l = 0; l < acpo_pkg::LANES; l++) begin
                pool_q[l].valid <= close_win[l];
                pool_q[l].last  <= close_win[l] & act_i[l].last;
                if (act_i[l].valid) begin
                    if (close_win[l]) begin
                        cnt[l]          <= '0;                // flush, next sample reopens
                        pool_q[l].value <= cur_max[l];
                        pool_q[l].tag   <= cur_tag[l];
                    end else begin
                        cnt[l]          <= cnt[l] + 1'b1;
                    end
                    run_max[l]   <= cur_max[l];
                    first_tag[l] <= cur_tag[l];
                end
            end
        end
    end

    assign pool_o = pool_q;

endmodule

//--- design/act_relu.sv
/* ReLU and byte saturation */
`timescale 1ns/1ps

module act_relu (
    input  logic                clk,
    input  logic                rst_n_i,
    input  acpo_pkg::acc_beat_t acc_i    [acpo_pkg::LANES],
    input  acpo_pkg::fc_beat_t  acc_fc_i,
    output acpo_pkg::act_beat_t act_o    [acpo_pkg::LANES],
    output acpo_pkg::act_fc_t   act_fc_o
);

    // clamp a signed accumulator result to 0..255
    function automatic acpo_pkg::data_t relu_sat(
        input logic signed [acpo_pkg::ACC_W-1:0] acc
    );
        acpo_pkg::data_t res;
        if (acc[acpo_pkg::ACC_W-1]) begin
            res = '0;                                              // negative
        end else if (|acc[acpo_pkg::ACC_W-2:acpo_pkg::DATA_W]) begin
            res = '1;                                              // above 255
        end else begin
            res = acc[acpo_pkg::DATA_W-1:0];
        end
        return res;
    endfunction

    acpo_pkg::act_beat_t act_q [acpo_pkg::LANES];
    acpo_pkg::act_fc_t   act_fc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int l = 0; l < acpo_pkg::LANES; l++) begin
                act_q[l].valid <= 1'b0;
                act_q[l].last  <= 1'b0;
            end
            act_fc_q.valid <= 1'b0;
            act_fc_q.last  <= 1'b0;
        end else begin
            for (int l = 0; l < acpo_pkg::LANES; l++) begin
                act_q[l].valid <= acc_i[l].valid;
                act_q[l].last  <= acc_i[l].valid & acc_i[l].last;
                act_q[l].value <= relu_sat(acc_i[l].result);
                act_q[l].tag   <= acc_i[l].tag;                    // tag rides along
            end
            act_fc_q.valid <= acc_fc_i.valid;
            act_fc_q.last  <= acc_fc_i.valid & acc_fc_i.last;
            act_fc_q.value <= relu_sat(acc_fc_i.result);
        end
    end

    assign act_o    = act_q;
    assign act_fc_o = act_fc_q;

endmodule

//--- design/acpo_pkg.sv
/* post-accumulation sizes and beat types */
package acpo_pkg;

    localparam int LANES     = 4;                 // conv lanes
    localparam int ACC_W     = 16;
    localparam int DATA_W    = 8;
    localparam int TAG_W     = 10;                // feature-map address tag
    localparam int POOL_SIZE = 4;                 // samples per window
    localparam int POOL_CW   = $clog2(POOL_SIZE);
    localparam int BUF_AW    = 6;
    localparam int BUF_DEPTH = 2 ** BUF_AW;       // entries per bank
    localparam int BANK_W    = 2;
    localparam int RD_AW     = BANK_W + BUF_AW;   // bank in top bits

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [TAG_W-1:0]  tag_t;

    // conv accumulator output
    typedef struct packed {
        logic                    valid;
        logic                    last;
        logic signed [ACC_W-1:0] result;
        tag_t                    tag;
    } acc_beat_t;

    // fc accumulator output
    typedef struct packed {
        logic                    valid;
        logic                    last;
        logic signed [ACC_W-1:0] result;
    } fc_beat_t;

    // activated or pooled conv beat
    typedef struct packed {
        logic  valid;
        logic  last;
        data_t value;
        tag_t  tag;
    } act_beat_t;

    typedef struct packed {
        logic  valid;
        logic  last;
        data_t value;
    } act_fc_t;

endpackage
